// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cadr_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cadr_pkg.sv ====
package cadr_pkg;

   typedef logic [14:0] vram_addr_t;   // word address into the frame memory
   typedef logic [31:0] vram_word_t;   // bit n is the pixel at column offset n
   typedef logic [7:0]  scan_code_t;

   // one request from the bus master to the frame memory
   typedef struct packed {
      vram_addr_t addr;
      vram_word_t wdata;
      logic       write;   // read when low
   } vram_req_t;

   // monochrome display output
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank;
      logic pixel;
   } vga_out_t;

   typedef enum logic [1:0] {
      ps2_idle,     // waiting for a start bit
      ps2_data,
      ps2_parity,
      ps2_stop
   } ps2_state_t;

   typedef enum logic {
      rst_hold,   // reset asserted while the stretch counter runs down
      rst_run
   } rst_state_t;

endpackage

// ==== cadr_unit.sv ====
`timescale 1ns/10ps

module cadr_unit #(
   parameter int h_active = 512,
   parameter int h_total = 640,
   parameter int v_active = 480,
   parameter int v_total = 500,
   parameter int h_sync_start = 528,
   parameter int h_sync_len = 64,
   parameter int v_sync_start = 485,
   parameter int v_sync_len = 2,
   parameter int reset_cycles = 16
) (
   input  logic                 clk50,
   input  logic                 rst_n,
   input  logic [3:0]           switch,
   input  logic                 ps2_clk,
   input  logic                 ps2_data,
   input  cadr_pkg::vram_req_t  cpu_req,
   input  logic                 cpu_req_valid,
   output logic                 cpu_req_ready,
   output cadr_pkg::vram_word_t cpu_rdata,
   output logic                 cpu_rdata_valid,
   output cadr_pkg::vga_out_t   vga_out,
   output cadr_pkg::scan_code_t kb_code,
   output logic                 kb_valid,
   input  logic                 kb_ready,
   output logic [3:0]           led
);
   import cadr_pkg::*;

   localparam int words = (h_active / 32) * v_active;   // one bit per pixel

   logic       sys_reset;
   logic       halt;
   logic       kb_overrun;
   vram_addr_t fetch_addr;
   logic       fetch_req;
   vram_word_t fetch_word;
   logic       fetch_grant;

   support #(
      .reset_cycles(reset_cycles)
   ) support0 (
      .clk50(clk50),
      .rst_n(rst_n),
      .button_reset(switch[0]),
      .button_halt(switch[2]),
      .sys_reset(sys_reset),
      .halt(halt)
   );

   vram_controller #(
      .words(words)
   ) vram0 (
      .clk50(clk50),
      .sys_reset(sys_reset),
      .cpu_req(cpu_req),
      .cpu_req_valid(cpu_req_valid),
      .cpu_req_ready(cpu_req_ready),
      .cpu_rdata(cpu_rdata),
      .cpu_rdata_valid(cpu_rdata_valid),
      .fetch_addr(fetch_addr),
      .fetch_req(fetch_req),
      .fetch_word(fetch_word),
      .fetch_grant(fetch_grant)
   );

   vga_display #(
      .h_active(h_active),
      .h_total(h_total),
      .v_active(v_active),
      .v_total(v_total),
      .h_sync_start(h_sync_start),
      .h_sync_len(h_sync_len),
      .v_sync_start(v_sync_start),
      .v_sync_len(v_sync_len)
   ) vga0 (
      .clk50(clk50),
      .sys_reset(sys_reset),
      .fetch_addr(fetch_addr),
      .fetch_req(fetch_req),
      .fetch_word(fetch_word),
      .fetch_grant(fetch_grant),
      .vga_out(vga_out)
   );

   ps2_keyboard kbd0 (
      .clk50(clk50),
      .sys_reset(sys_reset),
      .ps2_clk(ps2_clk),
      .ps2_data(ps2_data),
      .kb_code(kb_code),
      .kb_valid(kb_valid),
      .kb_overrun(kb_overrun),
      .kb_ready(kb_ready)
   );

   assign led = {halt, kb_overrun, kb_valid, sys_reset};   // status lamps

endmodule

// ==== project.f ====
cadr_pkg.sv
support.sv
ps2_keyboard.sv
vram_controller.sv
vga_display.sv
cadr_unit.sv
tb_cadr_unit.sv

// ==== ps2_keyboard.sv ====
`timescale 1ns/10ps

module ps2_keyboard (
   input  logic                 clk50,
   input  logic                 sys_reset,
   input  logic                 ps2_clk,
   input  logic                 ps2_data,
   output cadr_pkg::scan_code_t kb_code,
   output logic                 kb_valid,
   output logic                 kb_overrun,
   input  logic                 kb_ready
);
   import cadr_pkg::*;

   ps2_state_t state;
   scan_code_t shreg;
   logic [2:0] clk_sync;    // bit 2 holds the previous synchronized level
   logic [1:0] data_sync;
   logic [2:0] bit_cnt;
   logic       parity_ok;
   logic       fall;
   logic       bit_in;
   logic       frame_ok;
   logic       full;

   assign fall = clk_sync[2] && !clk_sync[1];
   assign bit_in = data_sync[1];
   assign full = kb_valid && !kb_ready;   // holding register cannot take a code this cycle

   always_ff @(posedge clk50) begin
      if (sys_reset) begin
         clk_sync <= '1;   // idle bus is high
         data_sync <= '1;
      end else begin
         clk_sync <= {clk_sync[1:0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
      end
   end

   always_ff @(posedge clk50) begin
      if (sys_reset) begin
         state <= ps2_idle;
         bit_cnt <= '0;
         parity_ok <= 1'b0;
      end else if (fall) begin
         case (state)
            ps2_idle: begin
               bit_cnt <= '0;
               if (!bit_in)
                  state <= cadr_pkg::ps2_data;   // start bit
            end
            cadr_pkg::ps2_data: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7)
                  state <= ps2_parity;
            end
            ps2_parity: begin
               parity_ok <= ^{shreg, bit_in};   // odd parity over data and parity bit
               state <= ps2_stop;
            end
            default: state <= ps2_idle;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk50) begin
      if (fall && state == cadr_pkg::ps2_data)
         shreg <= {bit_in, shreg[7:1]};
   end

   // a bad parity or a low stop bit just drops the frame
   assign frame_ok = fall && (state == ps2_stop) && bit_in && parity_ok;

   always_ff @(posedge clk50) begin
      if (sys_reset) begin
         kb_valid <= 1'b0;
         kb_overrun <= 1'b0;
      end else begin
         if (frame_ok && !full)
            kb_valid <= 1'b1;
         else if (kb_ready)
            kb_valid <= 1'b0;
         if (frame_ok && full)
            kb_overrun <= 1'b1;   // held code is kept and the new one dropped
      end
   end

   always_ff @(posedge clk50) begin
      if (frame_ok && !full)
         kb_code <= shreg;
   end

endmodule

// ==== support.sv ====
`timescale 1ns/10ps

module support #(
   parameter int reset_cycles = 16
) (
   input  logic clk50,
   input  logic rst_n,
   input  logic button_reset,
   input  logic button_halt,
   output logic sys_reset,
   output logic halt
);
   import cadr_pkg::*;

   localparam int cnt_w = $clog2(reset_cycles + 1);

   rst_state_t       state;
   logic [cnt_w-1:0] cnt;
   logic [1:0]       reset_sync;
   logic [2:0]       halt_sync;   // bit 2 is the previous synchronized level
   logic             reset_req;
   logic             halt_rise;

   assign reset_req = !rst_n || reset_sync[1];
   assign halt_rise = halt_sync[1] && !halt_sync[2];

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         reset_sync <= '0;
         halt_sync <= '0;
         halt <= 1'b0;
      end else begin
         reset_sync <= {reset_sync[0], button_reset};
         halt_sync <= {halt_sync[1:0], button_halt};
         if (halt_rise)
            halt <= !halt;   // each press flips the halt state
      end
   end

   // reset stays up while a source is active, then runs down for reset_cycles clocks
   always_ff @(posedge clk50) begin
      if (reset_req) begin
         state <= rst_hold;
         cnt <= cnt_w'(reset_cycles - 1);
      end else begin
         case (state)
            rst_hold: begin
               if (cnt == '0)
                  state <= rst_run;
               else
                  cnt <= cnt - 1'b1;
            end
            default: state <= rst_run;
         endcase
      end
   end

   assign sys_reset = (state == rst_hold);

   // blocks downstream see reset on the same edge that samples rst_n low
   assert property (@(posedge clk50) !rst_n |=> sys_reset);

endmodule

// ==== tb_cadr_unit.sv ====
`timescale 1ns/10ps

module tb_cadr_unit;
   import cadr_pkg::*;

   localparam int h_active = 64;
   localparam int h_total = 80;
   localparam int v_active = 4;
   localparam int v_total = 6;
   localparam int h_sync_start = 68;
   localparam int h_sync_len = 4;
   localparam int v_sync_start = 4;
   localparam int v_sync_len = 1;
   localparam int reset_cycles = 16;
   localparam int words_per_line = h_active / 32;
   localparam int frame_words = words_per_line * v_active;
   localparam int ps2_half = 4;   // clk50 cycles per ps2 clock phase
   localparam int wait_limit = 2000;

   logic       clk50 = 1'b0;
   logic       rst_n;
   logic [3:0] switch;
   logic       ps2_clk;
   logic       ps2_data;
   vram_req_t  cpu_req;
   logic       cpu_req_valid;
   logic       cpu_req_ready;
   vram_word_t cpu_rdata;
   logic       cpu_rdata_valid;
   vga_out_t   vga_out;
   scan_code_t kb_code;
   logic       kb_valid;
   logic       kb_ready;
   logic [3:0] led;

   integer     seed;
   integer     ready_seed;   // own stream for the consumer so the order of processes does not matter
   vram_word_t shadow [frame_words];
   vram_word_t snap [words_per_line];   // words as the display fetched them
   scan_code_t expect_q [$];
   int         h = 0;
   int         v = 0;
   logic       prev_reset = 1'b1;
   logic       scan_arm = 1'b0;
   logic       scan_on = 1'b0;
   logic       consume_en = 1'b0;

   always #5 clk50 = !clk50;

   cadr_unit #(
      .h_active(h_active), .h_total(h_total), .v_active(v_active), .v_total(v_total),
      .h_sync_start(h_sync_start), .h_sync_len(h_sync_len),
      .v_sync_start(v_sync_start), .v_sync_len(v_sync_len), .reset_cycles(reset_cycles)
   ) dut0 (
      .clk50(clk50), .rst_n(rst_n), .switch(switch), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .cpu_req(cpu_req), .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
      .cpu_rdata(cpu_rdata), .cpu_rdata_valid(cpu_rdata_valid), .vga_out(vga_out),
      .kb_code(kb_code), .kb_valid(kb_valid), .kb_ready(kb_ready), .led(led)
   );

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input vram_word_t exp, input vram_word_t act);
      if (act !== exp)
         stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_vga(input string name, input vga_out_t exp, input vga_out_t act);
      if (act !== exp)
         stop_run($sformatf("mismatch %s expected %b actual %b (h %0d v %0d)",
                            name, exp, act, h, v));
   endtask

   task automatic check_code(input string name, input scan_code_t exp, input scan_code_t act);
      if (act !== exp)
         stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
         stop_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
   endtask

   task automatic wait_led(input int idx, input logic value, input string what);
      int waited;
      waited = 0;
      while (led[idx] !== value) begin
         if (waited > wait_limit)
            stop_run($sformatf("timed out waiting for %s", what));
         @(negedge clk50);
         waited++;
      end
   endtask

   // raster model, one pixel per clock, parked three pixels before the frame in reset
   always @(negedge clk50) begin
      int       nv;
      logic     active;
      logic     fetch_due;
      vga_out_t exp;
      if (prev_reset) begin
         h = h_total - 3;
         v = v_total - 1;
      end else if (h == h_total - 1) begin
         h = 0;
         v = (v == v_total - 1) ? 0 : v + 1;
      end else begin
         h = h + 1;
      end
      prev_reset = (led[0] !== 1'b0);
      nv = (v == v_total - 1) ? 0 : v + 1;
      active = (h < h_active) && (v < v_active);
      fetch_due = ((h == h_total - 2) && (nv < v_active))
               || ((h % 32 == 30) && (h / 32 < words_per_line - 1) && (v < v_active));
      exp.hsync = (h >= h_sync_start) && (h < h_sync_start + h_sync_len);
      exp.vsync = (v >= v_sync_start) && (v < v_sync_start + v_sync_len);
      exp.blank = !active;
      exp.pixel = 1'b0;
      if (active)
         exp.pixel = snap[h / 32][h % 32];
      if (scan_on) begin
         check_vga("scanout", exp, vga_out);
         check_flag("cpu_req_ready", (led[0] === 1'b0) && !fetch_due, cpu_req_ready);
      end
      // the fetch reads memory on the coming edge, when no CPU write can land
      if (fetch_due && h == h_total - 2)
         snap[0] = shadow[nv * words_per_line];
      else if (fetch_due)
         snap[h / 32 + 1] = shadow[v * words_per_line + h / 32 + 1];
      if (scan_arm && fetch_due && h == h_total - 2 && nv == 0)
         scan_on = 1'b1;
   end

   always @(negedge clk50) begin
      if (consume_en) begin
         kb_ready = ($random(ready_seed) & 1) != 0;
         if (kb_valid === 1'b1 && kb_ready) begin
            if (expect_q.size() == 0)
               stop_run("keyboard delivered a code that was never sent");
            else
               check_code("scan code", expect_q.pop_front(), kb_code);
         end
      end
   end

   task automatic cpu_access(input logic write, input vram_addr_t addr, input vram_word_t data);
      int waited;
      waited = 0;
      @(negedge clk50);
      cpu_req.addr = addr;
      cpu_req.wdata = data;
      cpu_req.write = write;
      cpu_req_valid = 1'b1;
      while (cpu_req_ready !== 1'b1) begin   // request stays up through stalls
         if (waited > wait_limit)
            stop_run("cpu request was never accepted");
         @(negedge clk50);
         waited++;
      end
      if (write)
         shadow[addr] = data;
      @(negedge clk50);
      cpu_req_valid = 1'b0;
      check_flag(write ? "write response" : "read response", !write, cpu_rdata_valid);
      if (!write)
         check_word($sformatf("read of word %0d", addr), shadow[addr], cpu_rdata);
   endtask

   task automatic random_traffic(input int count);
      vram_addr_t addr;
      vram_word_t data;
      logic       write;
      for (int i = 0; i < count; i++) begin
         addr = vram_addr_t'({$random(seed)} % frame_words);
         data = $random(seed);
         write = ($random(seed) & 1) != 0;
         cpu_access(write, addr, data);
         repeat ({$random(seed)} % 3) @(negedge clk50);
      end
   endtask

   // start bit, eight data bits lsb first, parity, stop
   task automatic ps2_send(input scan_code_t code, input logic good_parity);
      logic [10:0] frame;
      frame = {1'b1, (~^code) ^ !good_parity, code, 1'b0};
      for (int i = 0; i < 11; i++) begin
         @(negedge clk50);
         ps2_data = frame[i];
         repeat (ps2_half) @(negedge clk50);
         ps2_clk = 1'b0;
         repeat (ps2_half) @(negedge clk50);
         ps2_clk = 1'b1;
      end
      repeat (2 * ps2_half) @(negedge clk50);
   endtask

   initial begin
      scan_code_t code_a;
      scan_code_t code_b;
      logic       good;
      logic       old_halt;
      int         high_cycles;
      int         waited;
      vga_out_t   idle_view;
      seed = 32'hc90a_c2c9;
      ready_seed = ~32'hc90a_c2c9;
      rst_n = 1'b0;
      switch = 4'b0;
      ps2_clk = 1'b1;
      ps2_data = 1'b1;
      cpu_req = '0;
      cpu_req_valid = 1'b0;
      kb_ready = 1'b0;
      idle_view = '0;
      idle_view.blank = 1'b1;
      repeat (8) @(negedge clk50);
      check_vga("display in reset", idle_view, vga_out);
      check_flag("cpu_rdata_valid in reset", 1'b0, cpu_rdata_valid);
      check_flag("kb_valid in reset", 1'b0, kb_valid);
      check_flag("reset led", 1'b1, led[0]);
      rst_n = 1'b1;
      wait_led(0, 1'b0, "end of reset");
      check_flag("halt led after reset", 1'b0, led[3]);

      for (int a = 0; a < frame_words; a++)
         cpu_access(1'b1, vram_addr_t'(a), $random(seed));
      random_traffic(60);

      scan_arm = 1'b1;
      waited = 0;
      while (!scan_on) begin
         if (waited > wait_limit)
            stop_run("display never reached the start of a frame");
         @(negedge clk50);
         waited++;
      end
      repeat (h_total * v_total) @(negedge clk50);

      fork
         random_traffic(80);
         repeat (h_total * v_total) @(negedge clk50);
      join

      @(posedge clk50);
      consume_en = 1'b1;
      for (int i = 0; i < 12; i++) begin
         code_a = $random(seed);
         good = ({$random(seed)} % 4) != 0;
         if (good)
            expect_q.push_back(code_a);
         ps2_send(code_a, good);
      end
      waited = 0;
      while (expect_q.size() != 0) begin
         if (waited > wait_limit)
            stop_run("keyboard codes were not all delivered");
         @(negedge clk50);
         waited++;
      end
      repeat (50) @(negedge clk50);   // nothing else may arrive
      @(posedge clk50);
      consume_en = 1'b0;
      @(negedge clk50);
      kb_ready = 1'b0;
      check_flag("overrun led after stream", 1'b0, led[2]);

      code_a = $random(seed);
      code_b = $random(seed);
      ps2_send(code_a, 1'b1);
      ps2_send(code_b, 1'b1);
      wait_led(2, 1'b1, "keyboard overrun");
      check_flag("kb_valid led", 1'b1, led[1]);
      check_code("held code after overrun", code_a, kb_code);

      switch[0] = 1'b1;
      @(negedge clk50);
      switch[0] = 1'b0;
      wait_led(0, 1'b1, "reset from switch 0");
      high_cycles = 0;
      while (led[0] === 1'b1) begin
         if (high_cycles > wait_limit)
            stop_run("reset from switch 0 never ended");
         high_cycles++;
         @(negedge clk50);
      end
      check_count("reset length", reset_cycles, high_cycles);
      check_flag("overrun led after reset", 1'b0, led[2]);
      check_flag("kb_valid led after reset", 1'b0, led[1]);

      old_halt = led[3];
      switch[2] = 1'b1;
      wait_led(3, !old_halt, "halt toggle on");
      repeat (5) @(negedge clk50);
      switch[2] = 1'b0;
      repeat (5) @(negedge clk50);
      check_flag("halt held after release", !old_halt, led[3]);
      switch[2] = 1'b1;
      wait_led(3, old_halt, "halt toggle off");
      switch[2] = 1'b0;
      repeat (h_total) @(negedge clk50);

      $display("Test passed");
      $finish;
   end

endmodule

// ==== vga_display.sv ====
`timescale 1ns/10ps

module vga_display #(
   parameter int h_active = 512,
   parameter int h_total = 640,
   parameter int v_active = 480,
   parameter int v_total = 500,
   parameter int h_sync_start = 528,
   parameter int h_sync_len = 64,
   parameter int v_sync_start = 485,
   parameter int v_sync_len = 2
) (
   input  logic                 clk50,
   input  logic                 sys_reset,
   output cadr_pkg::vram_addr_t fetch_addr,
   output logic                 fetch_req,
   input  cadr_pkg::vram_word_t fetch_word,
   input  logic                 fetch_grant,
   output cadr_pkg::vga_out_t   vga_out
);
   import cadr_pkg::*;

   localparam int hw = $clog2(h_total + 1);
   localparam int vw = $clog2(v_total + 1);
   localparam int frame_words = (h_active / 32) * v_active;

   logic [hw-1:0] h_cnt;
   logic [vw-1:0] v_cnt;
   logic [vw-1:0] v_next;
   vram_addr_t    next_addr;     // word address of the next fetch
   vram_word_t    shifter;
   logic          fetch_pending;   // fetch_word carries a fresh word this cycle
   logic          line_end;
   logic          line_active;
   logic          next_line_active;
   logic          active;
   logic          boundary;

   assign line_end = (h_cnt == hw'(h_total - 1));
   assign v_next = (v_cnt == vw'(v_total - 1)) ? '0 : v_cnt + 1'b1;
   assign line_active = (v_cnt < vw'(v_active));
   assign next_line_active = (v_next < vw'(v_active));
   assign active = (h_cnt < hw'(h_active)) && line_active;

   // ask two pixels ahead of each word boundary, for word 0 at the end of the previous line
   assign fetch_req = ((h_cnt[4:0] == 5'd30) && (h_cnt < hw'(h_active - 2)) && line_active)
                   || ((h_cnt == hw'(h_total - 2)) && next_line_active);
   assign fetch_addr = next_addr;

   // shifter is reloaded on the edge that ends this cycle
   assign boundary = ((h_cnt[4:0] == 5'd31) && (h_cnt < hw'(h_active - 1)) && line_active)
                  || (line_end && next_line_active);

   always_ff @(posedge clk50) begin
      if (sys_reset) begin
         // park three clocks before the frame so the first word is fetched in time
         h_cnt <= hw'(h_total - 3);
         v_cnt <= vw'(v_total - 1);
         next_addr <= '0;
         fetch_pending <= 1'b0;
      end else begin
         h_cnt <= line_end ? '0 : h_cnt + 1'b1;
         if (line_end)
            v_cnt <= v_next;
         if (fetch_req && fetch_grant)
            next_addr <= (next_addr == vram_addr_t'(frame_words - 1)) ? '0 : next_addr + 1'b1;
         fetch_pending <= fetch_req && fetch_grant;
      end
   end

   // pixel n of a word leaves n clocks after the load
   always_ff @(posedge clk50) begin
      if (fetch_pending)
         shifter <= fetch_word;
      else
         shifter <= {1'b0, shifter[31:1]};
   end

   assign vga_out.hsync = (h_cnt >= hw'(h_sync_start))
                       && (h_cnt < hw'(h_sync_start + h_sync_len));
   assign vga_out.vsync = (v_cnt >= vw'(v_sync_start))
                       && (v_cnt < vw'(v_sync_start + v_sync_len));
   assign vga_out.blank = !active;
   assign vga_out.pixel = active && shifter[0];

   // the memory must have granted the fetch one clock before every word boundary
   assert property (@(posedge clk50) disable iff (sys_reset) boundary |-> fetch_pending);

endmodule

// ==== vram_controller.sv ====
`timescale 1ns/10ps

module vram_controller #(
   parameter int words = 7680
) (
   input  logic                 clk50,
   input  logic                 sys_reset,
   input  cadr_pkg::vram_req_t  cpu_req,
   input  logic                 cpu_req_valid,
   output logic                 cpu_req_ready,
   output cadr_pkg::vram_word_t cpu_rdata,
   output logic                 cpu_rdata_valid,
   input  cadr_pkg::vram_addr_t fetch_addr,
   input  logic                 fetch_req,
   output cadr_pkg::vram_word_t fetch_word,
   output logic                 fetch_grant
);
   import cadr_pkg::*;

   localparam int aw = (words > 1) ? $clog2(words) : 1;

   vram_word_t mem [words];
   vram_word_t rd_data;
   logic       cpu_fire;
   logic       cpu_read;

   // the display cannot wait, so it wins every cycle it asks
   assign fetch_grant = fetch_req;
   assign cpu_req_ready = !sys_reset && !fetch_req;

   assign cpu_fire = cpu_req_valid && cpu_req_ready;
   assign cpu_read = cpu_fire && !cpu_req.write;

   // single port memory with one access per cycle
   always_ff @(posedge clk50) begin
      if (fetch_grant) begin
         rd_data <= mem[fetch_addr[aw-1:0]];
      end else if (cpu_fire) begin
         if (cpu_req.write)
            mem[cpu_req.addr[aw-1:0]] <= cpu_req.wdata;
         else
            rd_data <= mem[cpu_req.addr[aw-1:0]];
      end
   end

   // read data is shared by both clients and is only valid the cycle after access
   always_ff @(posedge clk50) begin
      if (sys_reset)
         cpu_rdata_valid <= 1'b0;
      else
         cpu_rdata_valid <= cpu_read;
   end

   assign cpu_rdata = rd_data;
   assign fetch_word = rd_data;

   // the display leaves the CPU a free slot after every fetch
   assert property (@(posedge clk50) fetch_req |=> !fetch_req);

   assert property (@(posedge clk50) disable iff (sys_reset)
      cpu_rdata_valid |-> $past(cpu_req_valid && cpu_req_ready && !cpu_req.write));

endmodule
